// File: sd_card_input.txt
# op  index  argument  expected R1, all hex
# badcrc breaks the CRC7 of a command, or the data CRC16 of a CMD24 write.
# Initialization
cmd       00  00000000  01
cmd       08  000001AA  01
cmd       37  00000000  01
cmd       29  40000000  01
cmd       37  00000000  01
cmd       29  40000000  00
cmd       3B  00000000  00
cmd       10  00000200  00
cmd       08  0000015A  00
# Command errors
badcrc    0D  00000000  08
cmd       05  00000000  04
cmd       29  40000000  04
cmd       10  00000400  40
cmd       0D  00000000  00
# Block writes and reads
write     18  00000000  00
read      11  00000000  00
write     18  00000003  00
read      11  00000003  00
badcrc    18  00000002  00
read      11  00000002  00
read      11  00000000  00
# Out of range
read      11  00000004  00
write     18  00000004  40
# Deselect in the middle of a frame
deselect  0D  00000000  00
cmd       0D  00000000  00

// File: all.f
sd_pkg.sv
sd_cmd_rx.sv
sd_crc16.sv
sd_block_ram.sv
sd_card_ctrl.sv
sd_card.sv
tb_clock_gen.sv
tb_sd_card.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sd_card -f all.f -o tb_sd_card \
  && ./obj_dir/tb_sd_card > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }
cat sim.log
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_sd_card.sv
`timescale 1ns/1ps

module tb_sd_card;
  import sd_pkg::*;

  localparam int CYCLES_PER_TEST = 12000;

  logic       sck;
  logic       arst_n;
  logic       cs_n;
  logic       mosi;
  logic       miso;
  logic       miso_en;

  logic       cs_level;                                   // Goes onto cs_n at the next drive point.
  logic       en_seen;                                    // miso_en at the last sample point.
  int         num_tests;
  int         error_count;
  int         test_errors;
  int         failed_tests;
  logic [7:0] shadow [NUM_BLOCKS][BLOCK_BYTES];

  tb_clock_gen clk_gen_i (
    .sck    (sck),
    .arst_n (arst_n)
  );

  sd_card dut_i (
    .sck     (sck),
    .arst_n  (arst_n),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso),
    .miso_en (miso_en)
  );

  // ====================================================================
  // Host side CRCs and frames
  // ====================================================================
  function automatic logic [6:0] crc7_calc(input logic [39:0] data);
    logic [6:0] c;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      if (c[6] ^ data[i]) c = {c[5:0], 1'b0} ^ 7'h09;     // x^7 + x^3 + 1.
      else c = {c[5:0], 1'b0};
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in, input logic [7:0] data);
    logic [15:0] c;
    c = crc_in ^ {data, 8'h00};
    for (int i = 0; i < 8; i++) begin
      if (c[15]) c = {c[14:0], 1'b0} ^ 16'h1021;
      else c = {c[14:0], 1'b0};
    end
    return c;
  endfunction

  function automatic logic [47:0] make_frame(input logic [5:0] idx, input logic [31:0] arg,
                                             input logic bad_crc);
    logic [6:0] c;
    c = crc7_calc({2'b01, idx, arg});
    if (bad_crc) c = c ^ 7'h01;
    return {2'b01, idx, arg, c, 1'b1};
  endfunction

  task automatic flag_error(input logic wrong_value, input string msg);
    if (wrong_value) $display("[FAIL] %0t: %s", $time, msg);
    else $display("%s", msg);
    error_count++;
    test_errors++;
  endtask

  // One bit slot. Drive after the edge, sample just before the next one.
  task automatic xfer(input logic tx, output logic rx);
    @(posedge sck);
    #5;
    cs_n = cs_level;
    mosi = tx;
    #90;
    rx      = miso;
    en_seen = miso_en;
  endtask

  task automatic send_bits(input logic [47:0] bits, input int n);
    logic rx;
    for (int i = n - 1; i >= 0; i--) xfer(bits[i], rx);
  endtask

  task automatic recv_byte(output logic [7:0] data);
    logic rx;
    for (int i = 7; i >= 0; i--) begin
      xfer(1'b1, rx);
      data[i] = rx;
    end
  endtask

  // A byte starts at the first 0 seen on miso.
  task automatic find_byte(input int limit, input string what, output logic [7:0] data,
                           output logic found);
    logic rx;
    int   n;
    found = 1'b0;
    n     = 0;
    data  = 8'hFF;
    while (!found && n < limit) begin
      xfer(1'b1, rx);
      found = !rx;
      n++;
    end
    if (!found) begin
      flag_error(1'b0, $sformatf("No %s came from the card within %0d cycles", what, limit));
    end else begin
      if (en_seen !== 1'b1) flag_error(1'b1, "miso_en is low while the card answers");
      data[7] = 1'b0;
      for (int i = 6; i >= 0; i--) begin
        xfer(1'b1, rx);
        data[i] = rx;
      end
    end
  endtask

  // ====================================================================
  // Transactions
  // ====================================================================
  task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg,
                         input logic [7:0] exp_r1, input logic bad_crc);
    logic [7:0]  r1, b;
    logic [31:0] r7;
    logic        found;
    send_bits(make_frame(idx, arg, bad_crc), 48);
    find_byte(16, "R1", r1, found);
    if (found) begin
      if (r1 !== exp_r1) flag_error(1'b1, $sformatf("CMD%0d R1 %h, expected %h", idx, r1, exp_r1));
      if (!bad_crc && idx == CMD8) begin
        r7 = '0;
        for (int i = 0; i < 4; i++) begin
          recv_byte(b);
          r7 = {r7[23:0], b};
        end
        if (r7 !== {24'h000001, arg[7:0]})
          flag_error(1'b1, $sformatf("R7 tail %h, expected 000001%h", r7, arg[7:0]));
      end
      if (!bad_crc && idx == CMD13) begin
        recv_byte(b);
        if (b !== 8'h00) flag_error(1'b1, $sformatf("R2 second byte %h, expected 00", b));
      end
    end
    send_bits('1, 8);
  endtask

  task automatic run_write(input logic [31:0] blk, input logic [7:0] exp_r1, input logic bad_crc);
    logic [7:0]  r1, dresp, data;
    logic [15:0] crc;
    logic        found, rx;
    int          zeros;
    send_bits(make_frame(CMD24, blk, 1'b0), 48);
    find_byte(16, "R1", r1, found);
    if (found && r1 !== exp_r1) flag_error(1'b1, $sformatf("CMD24 R1 %h, expected %h", r1, exp_r1));
    if (found && r1 == 8'h00) begin
      send_bits('1, 8);
      send_bits({40'd0, TOKEN_START}, 8);
      crc = '0;
      for (int i = 0; i < BLOCK_BYTES; i++) begin
        data = 8'($urandom);
        shadow[blk[BLK_W-1:0]][i] = data;                 // Stored even when the CRC is bad.
        crc = crc16_byte(crc, data);
        send_bits({40'd0, data}, 8);
      end
      if (bad_crc) crc = ~crc;
      send_bits({32'd0, crc}, 16);
      find_byte(8, "data response", dresp, found);
      if (found && dresp !== (bad_crc ? DATA_CRC_ERR : DATA_ACCEPTED))
        flag_error(1'b1, $sformatf("Data response %h for block %0d", dresp, blk));
      if (found && !bad_crc) begin
        zeros = 0;
        xfer(1'b1, rx);
        while (!rx && zeros < 4 * BUSY_BITS) begin
          zeros++;
          xfer(1'b1, rx);
        end
        if (zeros != BUSY_BITS)
          flag_error(1'b1, $sformatf("Busy lasted %0d cycles, expected %0d", zeros, BUSY_BITS));
        if (!rx) flag_error(1'b0, "miso never returned to 1 after the busy period");
      end
    end
    send_bits('1, 8);
  endtask

  task automatic run_read(input logic [31:0] blk, input logic [7:0] exp_r1);
    logic [7:0]  r1, gap, tok, data;
    logic [15:0] crc, rx_crc;
    logic        found;
    int          bad;
    send_bits(make_frame(CMD17, blk, 1'b0), 48);
    find_byte(16, "R1", r1, found);
    if (found) begin
      if (r1 !== exp_r1) flag_error(1'b1, $sformatf("CMD17 R1 %h, expected %h", r1, exp_r1));
      recv_byte(gap);
      recv_byte(tok);
      if (gap !== 8'hFF) flag_error(1'b1, $sformatf("Gap before token is %h, expected ff", gap));
      if (blk >= NUM_BLOCKS) begin
        if (tok !== TOKEN_OUT_OF_RANGE) flag_error(1'b1, $sformatf("Error token %h", tok));
      end else if (tok !== TOKEN_START) begin
        flag_error(1'b1, $sformatf("Start token %h, expected %h", tok, TOKEN_START));
      end else begin
        crc = '0;
        bad = 0;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          recv_byte(data);
          crc = crc16_byte(crc, data);
          if (data !== shadow[blk[BLK_W-1:0]][i]) bad++;
        end
        recv_byte(rx_crc[15:8]);
        recv_byte(rx_crc[7:0]);
        if (bad != 0) flag_error(1'b1, $sformatf("%0d bytes of block %0d differ", bad, blk));
        if (rx_crc !== crc) flag_error(1'b1, $sformatf("CRC16 %h, expected %h", rx_crc, crc));
      end
    end
    send_bits('1, 8);
  endtask

  // Part of a frame, cs_n high for a while, then the whole command.
  task automatic run_deselect(input logic [5:0] idx, input logic [31:0] arg,
                              input logic [7:0] exp_r1);
    logic rx;
    send_bits(make_frame(idx, arg, 1'b0) >> 28, 20);
    cs_level = 1'b1;
    for (int i = 0; i < 8; i++) begin
      xfer(1'b1, rx);
      if (i > 0 && en_seen !== 1'b0) flag_error(1'b1, "miso_en is high while cs_n is high");
    end
    cs_level = 1'b0;
    send_bits('1, 8);
    run_cmd(idx, arg, exp_r1, 1'b0);
  endtask

  // Skips comment lines, then reads one test.
  task automatic next_entry(input int fd, output logic ok, output logic [63:0] op,
                            output logic [31:0] idx, output logic [31:0] arg,
                            output logic [31:0] exp_r1);
    int               n;
    logic [8*120-1:0] rest;
    ok = 1'b0;
    n  = $fscanf(fd, "%s", op);
    while (n == 1 && op == 64'("#")) begin
      void'($fgets(rest, fd));
      n = $fscanf(fd, "%s", op);
    end
    if (n == 1) ok = ($fscanf(fd, "%h %h %h", idx, arg, exp_r1) == 3);
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial begin : main
    int          fd;
    int          test_count;
    logic        ok;
    logic [63:0] op;
    logic [31:0] idx, arg, exp_r1;
    void'($urandom(32'ha8b2));
    cs_n         = 1'b1;
    mosi         = 1'b1;
    cs_level     = 1'b1;
    en_seen      = 1'b0;
    num_tests    = 0;
    error_count  = 0;
    test_errors  = 0;
    failed_tests = 0;
    test_count   = 0;
    fd = $fopen("sd_card_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sd_card_input.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      next_entry(fd, ok, op, idx, arg, exp_r1);
      while (ok) begin
        num_tests++;
        next_entry(fd, ok, op, idx, arg, exp_r1);
      end
      $fclose(fd);
      fd = $fopen("sd_card_input.txt", "r");
      wait (arst_n === 1'b1);
      cs_level = 1'b0;
      send_bits('1, 16);
      next_entry(fd, ok, op, idx, arg, exp_r1);
      while (ok) begin
        test_count++;
        test_errors = 0;
        case (op)
          64'("cmd"):      run_cmd(idx[5:0], arg, exp_r1[7:0], 1'b0);
          64'("read"):     run_read(arg, exp_r1[7:0]);
          64'("write"):    run_write(arg, exp_r1[7:0], 1'b0);
          64'("deselect"): run_deselect(idx[5:0], arg, exp_r1[7:0]);
          64'("badcrc"): begin
            if (idx[5:0] == CMD24) run_write(arg, exp_r1[7:0], 1'b1);  // Bad data CRC16.
            else run_cmd(idx[5:0], arg, exp_r1[7:0], 1'b1);
          end
          default: flag_error(1'b0, $sformatf("Test %0d has an unknown operation", test_count));
        endcase
        if (test_errors == 0) begin
          $display("test %0d %0s %h %h: ok", test_count, op, idx[5:0], arg);
        end else begin
          failed_tests++;
          $display("test %0d %0s %h %h: %0d wrong results", test_count, op, idx[5:0], arg,
                   test_errors);
        end
        next_entry(fd, ok, op, idx, arg, exp_r1);
      end
      $fclose(fd);
      $display("%0d tests, %0d passed, %0d failed, %0d errors", test_count,
               test_count - failed_tests, failed_tests, error_count);
      if (error_count == 0) $display("Finished with no errors");
      else $display("Finished with errors");
      $finish;
    end
  end

  initial begin : watchdog
    wait (num_tests > 0);
    repeat (num_tests * CYCLES_PER_TEST) @(posedge sck);
    $display("Timeout: the tests did not end within %0d clock cycles", num_tests * CYCLES_PER_TEST);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic sck,
  output logic arst_n
);

  localparam int RESET_CYCLES = 16;

  initial begin
    sck = 1'b0;
    forever #50 sck = !sck;                               // 100 ns period.
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge sck);
    #5;
    arst_n = 1'b1;
  end

endmodule

// File: sd_card.sv
`timescale 1ns/1ps

module sd_card (
  input  logic sck,
  input  logic arst_n,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic miso_en
);
  import sd_pkg::*;

  sd_cmd_t               cmd;
  logic                  cmd_valid;
  logic                  cmd_ready;

  logic                  crc_clear;
  logic                  crc_en;
  logic                  crc_bit;
  logic [15:0]           crc;

  logic [RAM_ADDR_W-1:0] ram_addr;
  logic                  ram_we;
  logic [7:0]            ram_wdata;
  logic [7:0]            ram_rdata;

  sd_cmd_rx cmd_rx_i (
    .sck       (sck),
    .arst_n    (arst_n),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready)
  );

  sd_card_ctrl ctrl_i (
    .sck       (sck),
    .arst_n    (arst_n),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_bit   (crc_bit),
    .crc       (crc),
    .ram_addr  (ram_addr),
    .ram_we    (ram_we),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .miso      (miso),
    .miso_en   (miso_en)
  );

  sd_crc16 crc16_i (
    .sck       (sck),
    .arst_n    (arst_n),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_bit   (crc_bit),
    .crc       (crc)
  );

  sd_block_ram ram_i (
    .sck       (sck),
    .ram_addr  (ram_addr),
    .ram_we    (ram_we),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

// File: sd_card_ctrl.sv
`timescale 1ns/1ps

module sd_card_ctrl (
  input  logic                          sck,
  input  logic                          arst_n,
  input  logic                          cs_n,
  input  logic                          mosi,
  input  sd_pkg::sd_cmd_t               cmd,
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  output logic                          crc_clear,
  output logic                          crc_en,
  output logic                          crc_bit,
  input  logic [15:0]                   crc,
  output logic [sd_pkg::RAM_ADDR_W-1:0] ram_addr,
  output logic                          ram_we,
  output logic [7:0]                    ram_wdata,
  input  logic [7:0]                    ram_rdata,
  output logic                          miso,
  output logic                          miso_en
);
  import sd_pkg::*;

  logic [2:0]        phase;
  logic [2:0]        resp_next;                           // Phase after the response.
  logic [5:0]        bit_cnt;
  logic [5:0]        resp_len;
  logic [BYTE_W-1:0] byte_idx;
  logic              is_read;
  logic              idle;
  logic              app_cmd;                             // Last command was CMD55.
  logic              acmd41_seen;

  logic [BLK_W-1:0]  blk;
  logic [39:0]       resp_sr;
  logic [15:0]       rx_sr;

  logic              take;
  logic              data_bit;
  logic              crc_match;
  logic              prefetch;
  logic [BYTE_W-1:0] rd_byte;

  logic              dec_idle;
  logic              dec_seen;
  logic              dec_app;
  logic              dec_read;
  logic              oor;
  logic [7:0]        idle_bit;
  logic [39:0]       dec_resp;
  logic [5:0]        dec_len;
  logic [2:0]        dec_next;

  assign cmd_ready = (phase == PH_WAIT) && !cs_n;
  assign take      = cmd_valid && cmd_ready;
  assign data_bit  = is_read ? ram_rdata[bit_cnt[2:0]] : mosi;
  assign crc_match = ({rx_sr[14:0], mosi} == crc);

  assign crc_clear = take;
  assign crc_en    = (phase == PH_DATA);
  assign crc_bit   = data_bit;

  // Next byte is fetched during the last bit of the current one.
  assign prefetch  = is_read && (phase == PH_DATA) && (bit_cnt == 6'd0);
  assign rd_byte   = byte_idx + BYTE_W'(prefetch);
  assign ram_addr  = {blk, rd_byte};
  assign ram_we    = !is_read && (phase == PH_DATA) && (bit_cnt == 6'd0);
  assign ram_wdata = {rx_sr[6:0], mosi};

  // ====================================================================
  // Command decode
  // ====================================================================
  always_comb begin
    dec_idle = idle;
    dec_seen = acmd41_seen;
    dec_app  = 1'b0;
    oor      = (cmd.arg.block_addr >= 32'(NUM_BLOCKS));
    if (cmd.crc_ok) begin
      if (cmd.index == CMD0) begin
        dec_idle = 1'b1;
        dec_seen = 1'b0;
      end else if (cmd.index == ACMD41 && app_cmd) begin
        if (acmd41_seen) dec_idle = 1'b0;                 // Second ACMD41 ends init.
        else dec_seen = 1'b1;
      end
      dec_app = (cmd.index == CMD55);
    end

    idle_bit = dec_idle ? R1_IDLE : 8'h00;
    dec_resp = {idle_bit, 32'hFFFF_FFFF};
    dec_len  = 6'd8;
    dec_next = PH_WAIT;
    dec_read = 1'b0;

    if (!cmd.crc_ok) begin
      dec_resp[39:32] = idle_bit | R1_CRC_ERR;
    end else begin
      case (cmd.index)
        CMD0, CMD55, CMD59: begin
          dec_len = 6'd8;                                 // Plain R1.
        end
        CMD8: begin
          dec_resp = {idle_bit, 24'h000001, cmd.arg.if_cond.check_pattern};
          dec_len  = 6'd40;
        end
        CMD13: begin
          dec_resp[31:24] = 8'h00;
          dec_len         = 6'd16;
        end
        CMD16: begin
          if (cmd.arg.block_addr != 32'(BLOCK_BYTES)) dec_resp[39:32] = idle_bit | R1_PARAM_ERR;
        end
        CMD17: begin
          dec_len = 6'd24;                                // R1, Nac gap, token.
          if (oor) begin
            dec_resp[23:16] = TOKEN_OUT_OF_RANGE;
          end else begin
            dec_resp[23:16] = TOKEN_START;
            dec_next        = PH_DATA;
            dec_read        = 1'b1;
          end
        end
        CMD24: begin
          if (oor) dec_resp[39:32] = idle_bit | R1_PARAM_ERR;
          else dec_next = PH_TOKEN;
        end
        ACMD41: begin
          if (!app_cmd) dec_resp[39:32] = idle_bit | R1_ILLEGAL;
        end
        default: dec_resp[39:32] = idle_bit | R1_ILLEGAL;
      endcase
    end
  end

  // ====================================================================
  // Phase sequencer
  // ====================================================================
  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      phase       <= PH_WAIT;
      resp_next   <= PH_WAIT;
      bit_cnt     <= '0;
      resp_len    <= '0;
      byte_idx    <= '0;
      is_read     <= 1'b0;
      idle        <= 1'b1;                                // Card powers up idle.
      app_cmd     <= 1'b0;
      acmd41_seen <= 1'b0;
      miso_en     <= 1'b0;
    end else begin
      miso_en <= !cs_n;
      if (cs_n) begin
        phase <= PH_WAIT;
      end else begin
        case (phase)
          PH_WAIT: begin
            if (take) begin
              phase       <= PH_NCR;
              bit_cnt     <= 6'd7;
              resp_len    <= dec_len;
              resp_next   <= dec_next;
              is_read     <= dec_read;
              byte_idx    <= '0;
              idle        <= dec_idle;
              app_cmd     <= dec_app;
              acmd41_seen <= dec_seen;
            end
          end
          PH_NCR: begin
            if (bit_cnt == 6'd0) begin
              phase   <= PH_RESP;
              bit_cnt <= resp_len - 6'd1;
            end else begin
              bit_cnt <= bit_cnt - 6'd1;
            end
          end
          PH_RESP, PH_DRESP: begin
            if (bit_cnt == 6'd0) begin
              phase   <= resp_next;
              bit_cnt <= (resp_next == PH_BUSY) ? 6'(BUSY_BITS - 1) : 6'd7;
            end else begin
              bit_cnt <= bit_cnt - 6'd1;
            end
          end
          PH_TOKEN: begin
            if ({rx_sr[6:0], mosi} == TOKEN_START) begin
              phase   <= PH_DATA;
              bit_cnt <= 6'd7;
            end
          end
          PH_DATA: begin
            if (bit_cnt == 6'd0) begin
              byte_idx <= byte_idx + 1'b1;
              bit_cnt  <= 6'd7;
              if (byte_idx == BYTE_W'(BLOCK_BYTES - 1)) begin
                phase   <= PH_CRC;
                bit_cnt <= 6'd15;
              end
            end else begin
              bit_cnt <= bit_cnt - 6'd1;
            end
          end
          PH_CRC: begin
            if (bit_cnt == 6'd0) begin
              if (is_read) begin
                phase <= PH_WAIT;
              end else begin
                phase     <= PH_DRESP;
                bit_cnt   <= 6'd7;
                resp_next <= crc_match ? PH_BUSY : PH_WAIT;
              end
            end else begin
              bit_cnt <= bit_cnt - 6'd1;
            end
          end
          default: begin                                  // Busy.
            if (bit_cnt == 6'd0) phase <= PH_WAIT;
            else bit_cnt <= bit_cnt - 6'd1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge sck) begin
    if (take) begin
      resp_sr <= dec_resp;
      blk     <= cmd.arg.block_addr[BLK_W-1:0];
    end else if (phase == PH_RESP || phase == PH_DRESP) begin
      resp_sr <= {resp_sr[38:0], 1'b1};
    end else if (phase == PH_CRC && bit_cnt == 6'd0) begin
      resp_sr <= {crc_match ? DATA_ACCEPTED : DATA_CRC_ERR, 32'hFFFF_FFFF};
    end

    if (take) rx_sr <= 16'hFFFF;                          // Idle line before the token.
    else if (phase == PH_TOKEN || phase == PH_DATA || phase == PH_CRC)
      rx_sr <= {rx_sr[14:0], mosi};
  end

  // ====================================================================
  // miso
  // ====================================================================
  always_comb begin
    case (phase)
      PH_RESP, PH_DRESP: miso = resp_sr[39];
      PH_DATA:           miso = is_read ? data_bit : 1'b1;
      PH_CRC:            miso = is_read ? crc[bit_cnt[3:0]] : 1'b1;
      PH_BUSY:           miso = 1'b0;
      default:           miso = 1'b1;
    endcase
  end

endmodule

// File: sd_block_ram.sv
`timescale 1ns/1ps

module sd_block_ram (
  input  logic                          sck,
  input  logic [sd_pkg::RAM_ADDR_W-1:0] ram_addr,
  input  logic                          ram_we,
  input  logic [7:0]                    ram_wdata,
  output logic [7:0]                    ram_rdata
);
  import sd_pkg::*;

  // ====================================================================
  // Byte store, block number in the upper address bits
  // ====================================================================
  logic [7:0] mem [NUM_BLOCKS*BLOCK_BYTES];

  always_ff @(posedge sck) begin
    if (ram_we) mem[ram_addr] <= ram_wdata;
    ram_rdata <= mem[ram_addr];                           // Old data on a write cycle.
  end

endmodule

// File: sd_crc16.sv
`timescale 1ns/1ps

module sd_crc16 (
  input  logic        sck,
  input  logic        arst_n,
  input  logic        crc_clear,
  input  logic        crc_en,
  input  logic        crc_bit,
  output logic [15:0] crc
);

  logic fb;

  // x^16 + x^12 + x^5 + 1, MSB first.
  assign fb = crc[15] ^ crc_bit;

  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      crc <= '0;
    end else if (crc_clear) begin
      crc <= '0;
    end else if (crc_en) begin
      crc <= {crc[14:12], crc[11] ^ fb, crc[10:5], crc[4] ^ fb, crc[3:0], fb};
    end
  end

endmodule

// File: sd_cmd_rx.sv
`timescale 1ns/1ps

module sd_cmd_rx (
  input  logic            sck,
  input  logic            arst_n,
  input  logic            cs_n,
  input  logic            mosi,
  output sd_pkg::sd_cmd_t cmd,
  output logic            cmd_valid,
  input  logic            cmd_ready
);
  import sd_pkg::*;

  logic        busy;                                      // Inside a frame.
  logic [5:0]  bit_cnt;                                   // Index of the bit being sampled.
  logic [46:0] shift_sr;
  logic [6:0]  crc7;
  logic        start;

  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = crc[6] ^ din;
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

  // A frame opens on a 0 only while the controller can take one.
  assign start = !cs_n && !cmd_valid && !busy && cmd_ready && !mosi;

  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      bit_cnt   <= '0;
      crc7      <= '0;
      cmd_valid <= 1'b0;
    end else if (cs_n) begin
      busy      <= 1'b0;
      bit_cnt   <= '0;
      cmd_valid <= 1'b0;
    end else if (cmd_valid) begin
      if (cmd_ready) cmd_valid <= 1'b0;                   // Taken.
    end else if (busy) begin
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt < 6'd40) crc7 <= crc7_next(crc7, mosi);
      if (bit_cnt == 6'd47) begin
        busy      <= 1'b0;
        cmd_valid <= 1'b1;
      end
    end else if (start) begin
      busy    <= 1'b1;
      bit_cnt <= 6'd1;
      crc7    <= '0;                                      // Start bit leaves CRC at zero.
    end
  end

  always_ff @(posedge sck) begin
    if (busy || start) shift_sr <= {shift_sr[45:0], mosi};
    // The end bit is still on mosi here.
    if (busy && !cmd_valid && bit_cnt == 6'd47) begin
      cmd.index  <= shift_sr[44:39];
      cmd.arg    <= shift_sr[38:7];
      cmd.crc_ok <= (shift_sr[6:0] == crc7) && mosi;
    end
  end

endmodule

// File: sd_pkg.sv
package sd_pkg;

  // ====================================================================
  // Sizes
  // ====================================================================
  localparam int BLOCK_BYTES = 512;
  localparam int NUM_BLOCKS  = 4;
  localparam int BUSY_BITS   = 16;                        // Busy length after a write.

  localparam int BYTE_W     = $clog2(BLOCK_BYTES);        // Byte offset within a block.
  localparam int BLK_W      = $clog2(NUM_BLOCKS);         // Block number.
  localparam int RAM_ADDR_W = BLK_W + BYTE_W;

  // ====================================================================
  // Command indices
  // ====================================================================
  localparam logic [5:0] CMD0   = 6'd0;                   // GO_IDLE_STATE.
  localparam logic [5:0] CMD8   = 6'd8;                   // SEND_IF_COND.
  localparam logic [5:0] CMD13  = 6'd13;                  // SEND_STATUS.
  localparam logic [5:0] CMD16  = 6'd16;                  // SET_BLOCKLEN.
  localparam logic [5:0] CMD17  = 6'd17;                  // READ_SINGLE_BLOCK.
  localparam logic [5:0] CMD24  = 6'd24;                  // WRITE_BLOCK.
  localparam logic [5:0] CMD55  = 6'd55;                  // APP_CMD.
  localparam logic [5:0] CMD59  = 6'd59;                  // CRC_ON_OFF.
  localparam logic [5:0] ACMD41 = 6'd41;                  // SD_SEND_OP_COND.

  // ====================================================================
  // R1 flags and tokens
  // ====================================================================
  localparam logic [7:0] R1_IDLE      = 8'h01;
  localparam logic [7:0] R1_ILLEGAL   = 8'h04;
  localparam logic [7:0] R1_CRC_ERR   = 8'h08;
  localparam logic [7:0] R1_PARAM_ERR = 8'h40;

  localparam logic [7:0] TOKEN_START        = 8'hFE;
  localparam logic [7:0] TOKEN_OUT_OF_RANGE = 8'h08;
  localparam logic [7:0] DATA_ACCEPTED      = 8'h05;
  localparam logic [7:0] DATA_CRC_ERR       = 8'h0B;

  // Controller phases.
  localparam logic [2:0] PH_WAIT  = 3'd0;
  localparam logic [2:0] PH_NCR   = 3'd1;
  localparam logic [2:0] PH_RESP  = 3'd2;
  localparam logic [2:0] PH_TOKEN = 3'd3;                 // Write, waiting for start token.
  localparam logic [2:0] PH_DATA  = 3'd4;
  localparam logic [2:0] PH_CRC   = 3'd5;
  localparam logic [2:0] PH_DRESP = 3'd6;
  localparam logic [2:0] PH_BUSY  = 3'd7;

  // ====================================================================
  // Command types
  // ====================================================================
  typedef struct packed {
    logic [19:0] reserved;
    logic [3:0]  vhs;                                     // Supply voltage.
    logic [7:0]  check_pattern;
  } sd_if_cond_t;

  // CMD8 reads the argument as interface conditions, the data commands as an address.
  typedef union packed {
    logic [31:0] block_addr;
    sd_if_cond_t if_cond;
  } sd_arg_u;

  typedef struct packed {
    logic [5:0] index;
    sd_arg_u    arg;
    logic       crc_ok;                                   // CRC7 and end bit good.
  } sd_cmd_t;

endpackage
